//--- rtl/tlb_consts.svh
// TLB constants
// Address, page and table sizes shared by all blocks of the translation unit

`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// Request and master port address width
`define TLB_ADDR_W 32
// 4 KiB pages
`define TLB_PAGE_BITS 12
`define TLB_PN_W (`TLB_ADDR_W - `TLB_PAGE_BITS)

// Translation table
`define TLB_NUM_ENTRIES 4
`define TLB_IDX_W 2

`define TLB_ID_W 4

// Configuration port, entry select in the upper bits and field in the lower bits
`define TLB_CFG_ADDR_W 4
`define TLB_CFG_DATA_W 32

`endif

//--- rtl/tlb_pkg.sv
// TLB package
// Entry layout, configuration field codes and the two views of a
// configuration data word

`include "tlb_consts.svh"

package tlb_pkg;

  // One translation entry, maps pages first_pn..last_pn onto base_pn onwards
  typedef struct packed {
    logic [`TLB_PN_W-1:0] first_pn;
    logic [`TLB_PN_W-1:0] last_pn;
    logic [`TLB_PN_W-1:0] base_pn;
    logic                 valid;
    logic                 read_only;
  } tlb_entry_t;

  // Field select, taken from the low configuration address bits
  typedef enum logic [1:0] {
    FIELD_FIRST = 2'd0,
    FIELD_LAST  = 2'd1,
    FIELD_BASE  = 2'd2,
    FIELD_FLAGS = 2'd3
  } cfg_field_e;

  // Page number view of a configuration word
  typedef struct packed {
    logic [`TLB_CFG_DATA_W-`TLB_PN_W-1:0] rsvd;
    logic [`TLB_PN_W-1:0]                 pn;
  } cfg_page_t;

  // Flags view of a configuration word
  typedef struct packed {
    logic [`TLB_CFG_DATA_W-3:0] rsvd;
    logic                       read_only;
    logic                       valid;
  } cfg_flags_t;

  typedef union packed {
    cfg_page_t  page;
    cfg_flags_t flags;
  } tlb_cfg_word_u;

endpackage

//--- rtl/tlb_lookup_if.sv
// TLB lookup result channel
// Carries one registered lookup result from the lookup stage to the route
// stage, with a valid/ready handshake

`include "tlb_consts.svh"

interface tlb_lookup_if;

  logic                   valid;
  logic                   ready;
  logic                   hit;
  logic                   read_only;
  // Index of the matching entry, for debug visibility
  logic [`TLB_IDX_W-1:0]  idx;
  logic [`TLB_PN_W-1:0]   base_pn;
  logic [`TLB_PN_W-1:0]   first_pn;
  // Original request fields
  logic [`TLB_ADDR_W-1:0] addr;
  logic                   write;
  logic [`TLB_ID_W-1:0]   id;

  modport src (
    output valid, hit, read_only, idx, base_pn, first_pn, addr, write, id,
    input  ready
  );

  modport dst (
    input  valid, hit, read_only, base_pn, first_pn, addr, write, id,
    output ready
  );

endinterface

//--- rtl/tlb_cfg_decode.sv
// TLB configuration decoder
// Decodes single-cycle configuration writes into entry and field, and holds
// the translation table that the lookup stage compares against

`include "tlb_consts.svh"

module tlb_cfg_decode (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      cfg_we_i,
  input  logic [`TLB_CFG_ADDR_W-1:0]                cfg_addr_i,
  input  tlb_pkg::tlb_cfg_word_u                    cfg_wdata_i,
  output tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries_o
);

  logic [`TLB_IDX_W-1:0]  wr_idx;
  tlb_pkg::cfg_field_e    wr_field;
  logic                   flags_we;

  // Page fields of the table
  logic [`TLB_PN_W-1:0]   first_q [`TLB_NUM_ENTRIES];
  logic [`TLB_PN_W-1:0]   last_q  [`TLB_NUM_ENTRIES];
  logic [`TLB_PN_W-1:0]   base_q  [`TLB_NUM_ENTRIES];

  // Per-entry flags
  logic [`TLB_NUM_ENTRIES-1:0] valid_q;
  logic [`TLB_NUM_ENTRIES-1:0] ro_q;

  // Upper address bits pick the entry, lower bits pick the field
  assign wr_idx   = cfg_addr_i[`TLB_CFG_ADDR_W-1 -: `TLB_IDX_W];
  assign wr_field = tlb_pkg::cfg_field_e'(cfg_addr_i[`TLB_CFG_ADDR_W-`TLB_IDX_W-1:0]);
  assign flags_we = cfg_we_i && (wr_field == tlb_pkg::FIELD_FLAGS);

  // Page numbers come through the page view of the data word
  always_ff @(posedge clk_i) begin
    if (cfg_we_i) begin
      case (wr_field)
        tlb_pkg::FIELD_FIRST: begin
          first_q[wr_idx] <= cfg_wdata_i.page.pn;
        end
        tlb_pkg::FIELD_LAST: begin
          last_q[wr_idx] <= cfg_wdata_i.page.pn;
        end
        tlb_pkg::FIELD_BASE: begin
          base_q[wr_idx] <= cfg_wdata_i.page.pn;
        end
        default: begin
        end
      endcase
    end
  end

  // Flags come through the flags view, all entries invalid out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
      ro_q    <= '0;
    end else if (flags_we) begin
      valid_q[wr_idx] <= cfg_wdata_i.flags.valid;
      ro_q[wr_idx]    <= cfg_wdata_i.flags.read_only;
    end
  end

  // Present the table as entry structs
  always_comb begin
    for (int i = 0; i < `TLB_NUM_ENTRIES; i++) begin
      entries_o[i].first_pn  = first_q[i];
      entries_o[i].last_pn   = last_q[i];
      entries_o[i].base_pn   = base_q[i];
      entries_o[i].valid     = valid_q[i];
      entries_o[i].read_only = ro_q[i];
    end
  end

endmodule

//--- rtl/tlb_lookup.sv
// TLB lookup stage
// Compares the request page against all entries in parallel, picks the
// lowest hitting entry and registers the result for the route stage

`include "tlb_consts.svh"

module tlb_lookup (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries_i,
  input  logic                                      req_valid_i,
  output logic                                      req_ready_o,
  input  logic [`TLB_ADDR_W-1:0]                    req_addr_i,
  input  logic                                      req_write_i,
  input  logic [`TLB_ID_W-1:0]                      req_id_i,
  tlb_lookup_if.src                                 res
);

  logic [`TLB_PN_W-1:0]         req_pn;
  logic [`TLB_NUM_ENTRIES-1:0]  hit_vec;
  logic                         any_hit;
  logic [`TLB_IDX_W-1:0]        hit_idx;
  tlb_pkg::tlb_entry_t          hit_entry;
  logic                         req_fire;

  assign req_pn = req_addr_i[`TLB_ADDR_W-1:`TLB_PAGE_BITS];

  // One range comparator per entry
  always_comb begin
    for (int i = 0; i < `TLB_NUM_ENTRIES; i++) begin
      hit_vec[i] = entries_i[i].valid &&
                   (req_pn >= entries_i[i].first_pn) &&
                   (req_pn <= entries_i[i].last_pn);
    end
  end

  // Priority encoder, scanning downwards so the lowest index wins
  always_comb begin
    hit_idx = '0;
    for (int i = `TLB_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        hit_idx = i[`TLB_IDX_W-1:0];
      end
    end
  end

  assign any_hit   = |hit_vec;
  assign hit_entry = entries_i[hit_idx];

  // Stage accepts when empty or drained on this edge
  assign req_ready_o = !res.valid || res.ready;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res.valid <= 1'b0;
    end else if (req_fire) begin
      res.valid <= 1'b1;
    end else if (res.ready) begin
      res.valid <= 1'b0;
    end
  end

  // Result payload, held while the route stage stalls
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      res.hit       <= any_hit;
      res.idx       <= hit_idx;
      res.read_only <= hit_entry.read_only;
      res.base_pn   <= hit_entry.base_pn;
      res.first_pn  <= hit_entry.first_pn;
      res.addr      <= req_addr_i;
      res.write     <= req_write_i;
      res.id        <= req_id_i;
    end
  end

endmodule

//--- rtl/tlb_route.sv
// TLB route stage
// Applies write protection, forms the translated address and loads either
// the master or the error output register

`include "tlb_consts.svh"

module tlb_route (
  input  logic                    clk_i,
  input  logic                    reset_i,
  tlb_lookup_if.dst               res,
  // Master channel
  output logic                    mst_valid_o,
  input  logic                    mst_ready_i,
  output logic [`TLB_ADDR_W-1:0]  mst_addr_o,
  output logic                    mst_write_o,
  output logic [`TLB_ID_W-1:0]    mst_id_o,
  // Error channel
  output logic                    err_valid_o,
  input  logic                    err_ready_i,
  output logic [`TLB_ADDR_W-1:0]  err_addr_o,
  output logic                    err_write_o,
  output logic [`TLB_ID_W-1:0]    err_id_o
);

  logic                   to_mst;
  logic                   mst_free;
  logic                   err_free;
  logic                   res_fire;
  logic [`TLB_PN_W-1:0]   req_pn;
  logic [`TLB_PN_W-1:0]   xlat_pn;
  logic [`TLB_ADDR_W-1:0] xlat_addr;

  // Writes to read-only entries are treated like misses
  assign to_mst = res.hit && !(res.write && res.read_only);

  // Offset within the entry's range, rebased onto its base page
  assign req_pn    = res.addr[`TLB_ADDR_W-1:`TLB_PAGE_BITS];
  assign xlat_pn   = res.base_pn + (req_pn - res.first_pn);
  assign xlat_addr = {xlat_pn, res.addr[`TLB_PAGE_BITS-1:0]};

  // An output register is free when empty or drained on this edge
  assign mst_free  = !mst_valid_o || mst_ready_i;
  assign err_free  = !err_valid_o || err_ready_i;
  assign res.ready = to_mst ? mst_free : err_free;
  assign res_fire  = res.valid && res.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mst_valid_o <= 1'b0;
    end else if (res_fire && to_mst) begin
      mst_valid_o <= 1'b1;
    end else if (mst_ready_i) begin
      mst_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_valid_o <= 1'b0;
    end else if (res_fire && !to_mst) begin
      err_valid_o <= 1'b1;
    end else if (err_ready_i) begin
      err_valid_o <= 1'b0;
    end
  end

  // Payloads only change on a load, so they stay stable while valid is high
  always_ff @(posedge clk_i) begin
    if (res_fire && to_mst) begin
      mst_addr_o  <= xlat_addr;
      mst_write_o <= res.write;
      mst_id_o    <= res.id;
    end
    if (res_fire && !to_mst) begin
      // Error port keeps the untranslated address
      err_addr_o  <= res.addr;
      err_write_o <= res.write;
      err_id_o    <= res.id;
    end
  end

endmodule

//--- rtl/axi_tlb_lite.sv
// Lightweight address translation unit
// Translates 4 KiB pages of incoming address requests through a four-entry
// table, misses and protected writes are steered to the error port

`include "tlb_consts.svh"

module axi_tlb_lite (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Configuration writes
  input  logic                        cfg_we_i,
  input  logic [`TLB_CFG_ADDR_W-1:0]  cfg_addr_i,
  input  logic [`TLB_CFG_DATA_W-1:0]  cfg_wdata_i,
  // Request channel
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [`TLB_ADDR_W-1:0]      req_addr_i,
  input  logic                        req_write_i,
  input  logic [`TLB_ID_W-1:0]        req_id_i,
  // Master channel
  output logic                        mst_valid_o,
  input  logic                        mst_ready_i,
  output logic [`TLB_ADDR_W-1:0]      mst_addr_o,
  output logic                        mst_write_o,
  output logic [`TLB_ID_W-1:0]        mst_id_o,
  // Error channel
  output logic                        err_valid_o,
  input  logic                        err_ready_i,
  output logic [`TLB_ADDR_W-1:0]      err_addr_o,
  output logic                        err_write_o,
  output logic [`TLB_ID_W-1:0]        err_id_o
);

  tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries;

  tlb_lookup_if lookup_res ();

  tlb_cfg_decode cfg_decode_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (tlb_pkg::tlb_cfg_word_u'(cfg_wdata_i)),
    .entries_o   (entries)
  );

  tlb_lookup lookup_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .entries_i   (entries),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_write_i (req_write_i),
    .req_id_i    (req_id_i),
    .res         (lookup_res.src)
  );

  tlb_route route_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .res         (lookup_res.dst),
    .mst_valid_o (mst_valid_o),
    .mst_ready_i (mst_ready_i),
    .mst_addr_o  (mst_addr_o),
    .mst_write_o (mst_write_o),
    .mst_id_o    (mst_id_o),
    .err_valid_o (err_valid_o),
    .err_ready_i (err_ready_i),
    .err_addr_o  (err_addr_o),
    .err_write_o (err_write_o),
    .err_id_o    (err_id_o)
  );

endmodule

//--- bench/tlb_tb.sv
// Testbench for the address translation unit
// Mirrors the translation table, predicts the port and address of every
// accepted request and checks each master and error transfer against it

`include "tlb_consts.svh"

module tlb_tb;

  localparam int MAX_CYCLES = 4000;
  localparam int RAND_REQS  = 300;

  // Expected transfer, queued per destination port
  typedef struct packed {
    logic                   to_err;
    logic [`TLB_ADDR_W-1:0] addr;
    logic                   write;
    logic [`TLB_ID_W-1:0]   id;
    logic                   timed;
    int                     cyc;
  } exp_t;

  logic                       clk_i;
  logic                       reset_i;
  logic                       cfg_we_i;
  logic [`TLB_CFG_ADDR_W-1:0] cfg_addr_i;
  logic [`TLB_CFG_DATA_W-1:0] cfg_wdata_i;
  logic                       req_valid_i;
  logic                       req_ready_o;
  logic [`TLB_ADDR_W-1:0]     req_addr_i;
  logic                       req_write_i;
  logic [`TLB_ID_W-1:0]       req_id_i;
  logic                       mst_valid_o;
  logic                       mst_ready_i = 1'b1;
  logic [`TLB_ADDR_W-1:0]     mst_addr_o;
  logic                       mst_write_o;
  logic [`TLB_ID_W-1:0]       mst_id_o;
  logic                       err_valid_o;
  logic                       err_ready_i = 1'b1;
  logic [`TLB_ADDR_W-1:0]     err_addr_o;
  logic                       err_write_o;
  logic [`TLB_ID_W-1:0]       err_id_o;

  tlb_pkg::tlb_entry_t shadow [`TLB_NUM_ENTRIES];
  exp_t       mst_q [$];
  exp_t       err_q [$];
  exp_t       acc_exp;
  logic [1:0] rdy_pat [1024];
  logic [9:0] pat_idx = '0;
  logic       rand_ready;
  logic       timed_reqs;
  logic [31:0] rnd;
  int cycle = 0;
  int mst_seen = 0;
  int err_seen = 0;
  int cmp_errors = 0;
  int seq_errors = 0;
  int test_no = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int mst_base;
  int err_base;
  int fail_base;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  axi_tlb_lite axi_tlb_lite_inst (.*);

  // Expected destination and address, from the shadow table
  function automatic exp_t expect_route(input logic [`TLB_ADDR_W-1:0] addr,
                                        input logic write, input logic [`TLB_ID_W-1:0] id);
    exp_t                  e;
    logic [`TLB_PN_W-1:0]  pn;
    logic [`TLB_PN_W-1:0]  new_pn;
    logic [`TLB_IDX_W-1:0] hit_idx;
    logic                  found;
    pn      = addr[`TLB_ADDR_W-1:`TLB_PAGE_BITS];
    found   = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < `TLB_NUM_ENTRIES; i++) begin
      if (!found && shadow[i].valid && pn >= shadow[i].first_pn && pn <= shadow[i].last_pn) begin
        found   = 1'b1;
        hit_idx = i[`TLB_IDX_W-1:0];
      end
    end
    e       = '0;
    e.write = write;
    e.id    = id;
    if (found && !(write && shadow[hit_idx].read_only)) begin
      new_pn   = shadow[hit_idx].base_pn + (pn - shadow[hit_idx].first_pn);
      e.to_err = 1'b0;
      e.addr   = {new_pn, addr[`TLB_PAGE_BITS-1:0]};
    end else begin
      e.to_err = 1'b1;
      e.addr   = addr;
    end
    return e;
  endfunction

  task automatic compare_out(input logic to_err, input logic [`TLB_ADDR_W-1:0] addr,
                             input logic write, input logic [`TLB_ID_W-1:0] id);
    exp_t e;
    if (to_err ? (err_q.size() == 0) : (mst_q.size() == 0)) begin
      cmp_errors++;
      $display("Unexpected transfer on the %s port at time %0t, no request was waiting for it",
               to_err ? "error" : "master", $time);
    end else begin
      e = to_err ? err_q.pop_front() : mst_q.pop_front();
      assert (addr == e.addr) else begin
        cmp_errors++;
        $display("** Error @ %0t: id %h addr %h, expected %h", $time, id, addr, e.addr);
      end
      assert (write == e.write && id == e.id) else begin
        cmp_errors++;
        $display("** Error @ %0t: write %b id %h, expected %b %h",
                 $time, write, id, e.write, e.id);
      end
      if (e.timed) begin
        assert (cycle - e.cyc == 2) else begin
          cmp_errors++;
          $display("** Error @ %0t: latency %0d cycles, expected 2", $time, cycle - e.cyc);
        end
      end
    end
  endtask

  // Output readiness, random while the stress test runs
  always @(negedge clk_i) begin
    if (rand_ready) begin
      {mst_ready_i, err_ready_i} = rdy_pat[pat_idx];
      pat_idx = pat_idx + 10'd1;
    end else begin
      mst_ready_i = 1'b1;
      err_ready_i = 1'b1;
    end
  end

  // Compare outputs, queue accepted requests and watch the cycle limit
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (mst_valid_o && mst_ready_i) begin
        mst_seen++;
        compare_out(1'b0, mst_addr_o, mst_write_o, mst_id_o);
      end
      if (err_valid_o && err_ready_i) begin
        err_seen++;
        compare_out(1'b1, err_addr_o, err_write_o, err_id_o);
      end
      if (req_valid_i && req_ready_o) begin
        acc_exp       = expect_route(req_addr_i, req_write_i, req_id_i);
        acc_exp.cyc   = cycle;
        acc_exp.timed = timed_reqs;
        if (acc_exp.to_err) begin
          err_q.push_back(acc_exp);
        end else begin
          mst_q.push_back(acc_exp);
        end
      end
    end
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: the run reached %0d cycles before all tests finished", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Called right after a falling edge, returns after one
  task automatic cfg_write(input logic [`TLB_IDX_W-1:0] idx, input tlb_pkg::cfg_field_e field,
                           input logic [`TLB_PN_W-1:0] pn, input logic v, input logic ro);
    tlb_pkg::tlb_cfg_word_u w;
    w = '0;
    if (field == tlb_pkg::FIELD_FLAGS) begin
      w.flags.valid     = v;
      w.flags.read_only = ro;
    end else begin
      w.page.pn = pn;
    end
    cfg_we_i    = 1'b1;
    cfg_addr_i  = {idx, field};
    cfg_wdata_i = w;
    case (field)
      tlb_pkg::FIELD_FIRST: shadow[idx].first_pn = w.page.pn;
      tlb_pkg::FIELD_LAST:  shadow[idx].last_pn  = w.page.pn;
      tlb_pkg::FIELD_BASE:  shadow[idx].base_pn  = w.page.pn;
      default: begin
        shadow[idx].valid     = w.flags.valid;
        shadow[idx].read_only = w.flags.read_only;
      end
    endcase
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic set_entry(input logic [`TLB_IDX_W-1:0] idx, input logic [`TLB_PN_W-1:0] first,
                           input logic [`TLB_PN_W-1:0] last, input logic [`TLB_PN_W-1:0] base,
                           input logic ro);
    cfg_write(idx, tlb_pkg::FIELD_FIRST, first, 1'b0, 1'b0);
    cfg_write(idx, tlb_pkg::FIELD_LAST, last, 1'b0, 1'b0);
    cfg_write(idx, tlb_pkg::FIELD_BASE, base, 1'b0, 1'b0);
    cfg_write(idx, tlb_pkg::FIELD_FLAGS, '0, 1'b1, ro);
  endtask

  // Holds valid until the DUT accepts
  task automatic send_req(input logic [`TLB_ADDR_W-1:0] addr, input logic write,
                          input logic [`TLB_ID_W-1:0] id);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_write_i = write;
    req_id_i    = id;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic begin_test();
    test_no++;
    mst_base  = mst_seen;
    err_base  = err_seen;
    fail_base = seq_errors + cmp_errors;
  endtask

  // Drains both queues, then checks how many transfers went to each port
  task automatic end_test(input string name, input int exp_mst, input int exp_err);
    int fails;
    while (mst_q.size() != 0 || err_q.size() != 0) @(negedge clk_i);
    if (exp_mst >= 0) begin
      assert (mst_seen - mst_base == exp_mst && err_seen - err_base == exp_err) else begin
        seq_errors++;
        $display("** Error @ %0t: %0d master and %0d error transfers, expected %0d and %0d",
                 $time, mst_seen - mst_base, err_seen - err_base, exp_mst, exp_err);
      end
    end
    fails = seq_errors + cmp_errors - fail_base;
    if (fails == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d (%s): %s", test_no, name, (fails == 0) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(32'h28749081));
    reset_i     = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_write_i = 1'b0;
    req_id_i    = '0;
    rand_ready  = 1'b0;
    timed_reqs  = 1'b0;
    for (int i = 0; i < `TLB_NUM_ENTRIES; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    begin_test();
    assert (req_ready_o && !mst_valid_o && !err_valid_o) else begin
      seq_errors++;
      $display("** Error @ %0t: ready or valid outputs wrong after reset", $time);
    end
    send_req(32'h0000_5123, 1'b0, 4'h1);
    end_test("reset state and unconfigured miss", 0, 1);

    begin_test();
    set_entry(2'd0, 20'h00010, 20'h0001F, 20'h00080, 1'b0);
    set_entry(2'd1, 20'h00020, 20'h00027, 20'h00300, 1'b0);
    timed_reqs = 1'b1;
    send_req(32'h0001_3ABC, 1'b0, 4'h2);
    send_req(32'h0002_4010, 1'b1, 4'h3);
    send_req(32'h0001_F004, 1'b1, 4'h4);
    send_req(32'h0002_7FFC, 1'b0, 4'h5);
    end_test("read and write hits", 4, 0);
    timed_reqs = 1'b0;

    // Entry 2 overlaps the top of entry 0 and the bottom of entry 1
    begin_test();
    set_entry(2'd2, 20'h00018, 20'h00022, 20'h00500, 1'b0);
    send_req(32'h0000_FFFC, 1'b0, 4'h6);
    send_req(32'h0001_0000, 1'b0, 4'h7);
    send_req(32'h0001_FFFF, 1'b1, 4'h8);
    send_req(32'h0002_8000, 1'b1, 4'h9);
    send_req(32'h0001_C000, 1'b0, 4'hA);
    send_req(32'h0002_1000, 1'b1, 4'hB);
    send_req(32'h0002_3010, 1'b0, 4'hC);
    end_test("range edges and overlaps", 5, 2);

    begin_test();
    set_entry(2'd3, 20'h00040, 20'h00047, 20'h00900, 1'b1);
    send_req(32'h0004_1200, 1'b1, 4'hD);
    send_req(32'h0004_1200, 1'b0, 4'hE);
    end_test("read-only entry", 1, 1);

    begin_test();
    for (int k = 0; k < 1024; k++) begin
      rnd = $urandom;
      rdy_pat[k] = {rnd[0] | rnd[1], rnd[2] | rnd[3]};
    end
    @(posedge clk_i);
    rand_ready = 1'b1;
    @(negedge clk_i);
    for (int n = 0; n < RAND_REQS; n++) begin
      rnd = $urandom;
      send_req({13'h0, rnd[18:12], rnd[11:0]}, rnd[31], rnd[27:24]);
      if (rnd[30]) @(negedge clk_i);
    end
    @(posedge clk_i);
    rand_ready = 1'b0;
    @(negedge clk_i);
    end_test("random requests with back-pressure", -1, -1);

    begin_test();
    cfg_write(2'd1, tlb_pkg::FIELD_BASE, 20'h00700, 1'b0, 1'b0);
    send_req(32'h0002_5ABC, 1'b0, 4'h1);
    cfg_write(2'd1, tlb_pkg::FIELD_FLAGS, '0, 1'b0, 1'b0);
    send_req(32'h0002_5ABC, 1'b0, 4'h2);
    end_test("entry rewrite and invalidate", 1, 1);

    $display("Summary: %0d tests ok, %0d tests failed, %0d errors",
             tests_passed, tests_failed, seq_errors + cmp_errors);
    if (tests_failed == 0 && seq_errors + cmp_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/tlb_pkg.sv
rtl/tlb_lookup_if.sv
rtl/tlb_cfg_decode.sv
rtl/tlb_lookup.sv
rtl/tlb_route.sv
rtl/axi_tlb_lite.sv
bench/tlb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the TLB testbench with Verilator, runs it and checks the log

set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f project.f \
  --top-module tlb_tb \
  -o tlb_sim

./obj_dir/tlb_sim | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
